// File: logic/memBusPkg.sv
package memBusPkg;

    // byte-wide RAM port, 32-bit words on the processor side
    localparam int ADDR_WIDTH     = 32;
    localparam int BYTE_WIDTH     = 8;
    localparam int BYTES_PER_WORD = 4;
    localparam int WORD_WIDTH     = 32;
    localparam int LANE_WIDTH     = $clog2(BYTES_PER_WORD);

    typedef logic [ADDR_WIDTH-1:0] memAddr_t;
    typedef logic [BYTE_WIDTH-1:0] memByte_t;
    typedef logic [LANE_WIDTH-1:0] laneIdx_t;

    // same word seen whole or by byte lane, lane 0 is the lowest address
    typedef union packed {
        logic [WORD_WIDTH-1:0]               word;
        memByte_t [BYTES_PER_WORD-1:0]       lanes;
    } laneWord_t;

endpackage

// File: logic/memReqPkg.sv
package memReqPkg;

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSize_t;

    typedef enum logic {
        srcFetch = 1'b0,
        srcData  = 1'b1
    } reqSource_t;

    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } memOp_t;

    // 0 to 4 bytes
    typedef logic [2:0] byteCount_t;

    // bytes moved by one access of the given size
    function automatic byteCount_t bytesOf(accessSize_t size);
        case (size)
            sizeByte: return 3'd1;
            sizeHalf: return 3'd2;
            default:  return 3'd4;
        endcase
    endfunction

endpackage

// File: logic/requestArbiter.sv
`timescale 1ns/1ps

module requestArbiter
    import memBusPkg::*, memReqPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_fetchValid,
    input  memAddr_t              i_fetchAddr,
    input  logic                  i_dataValid,
    input  memOp_t                i_dataOp,
    input  accessSize_t           i_dataSize,
    input  memAddr_t              i_dataAddr,
    input  logic [WORD_WIDTH-1:0] i_dataWdata,
    input  logic                  i_reqReady,
    output logic                  o_fetchReady,
    output logic                  o_dataReady,
    output logic                  o_reqValid,
    output memOp_t                o_reqOp,
    output accessSize_t           o_reqSize,
    output reqSource_t            o_reqSource,
    output memAddr_t              o_reqAddr,
    output logic [WORD_WIDTH-1:0] o_reqWdata
);

    logic                  holdFree;
    logic                  heldValid;
    logic                  heldValidNext;
    memOp_t                heldOp;
    accessSize_t           heldSize;
    reqSource_t            heldSource;
    memAddr_t              heldAddr;
    logic [WORD_WIDTH-1:0] heldWdata;
    logic                  takeData;
    logic                  takeFetch;
    logic                  accept;

    // data always wins, fetch only sees ready when no data is pending
    assign o_dataReady  = holdFree;
    assign o_fetchReady = holdFree && !i_dataValid;

    assign takeData  = o_dataReady && i_dataValid;
    assign takeFetch = o_fetchReady && i_fetchValid;
    assign accept    = takeData || takeFetch;

    always_comb begin
        heldValidNext = heldValid;
        if (accept) begin
            heldValidNext = 1'b1;
        end else if (i_reqReady) begin
            heldValidNext = 1'b0;
        end
    end

    // holdFree tracks the empty holding register, but stays low one cycle out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            heldValid <= 1'b0;
            holdFree  <= 1'b0;
        end else begin
            heldValid <= heldValidNext;
            holdFree  <= !heldValidNext;
        end
    end

    always_ff @(posedge clk) begin
        if (takeData) begin
            heldOp     <= i_dataOp;
            heldSize   <= i_dataSize;
            heldSource <= srcData;
            heldAddr   <= i_dataAddr;
            heldWdata  <= i_dataWdata;
        end else if (takeFetch) begin
            // instruction fetch is always a word read
            heldOp     <= opRead;
            heldSize   <= sizeWord;
            heldSource <= srcFetch;
            heldAddr   <= i_fetchAddr;
            heldWdata  <= '0;
        end
    end

    assign o_reqValid  = heldValid;
    assign o_reqOp     = heldOp;
    assign o_reqSize   = heldSize;
    assign o_reqSource = heldSource;
    assign o_reqAddr   = heldAddr;
    assign o_reqWdata  = heldWdata;

endmodule

// File: logic/byteSequencer.sv
`timescale 1ns/1ps

module byteSequencer
    import memBusPkg::*, memReqPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_reqValid,
    input  memOp_t                i_reqOp,
    input  accessSize_t           i_reqSize,
    input  reqSource_t            i_reqSource,
    input  memAddr_t              i_reqAddr,
    input  logic [WORD_WIDTH-1:0] i_reqWdata,
    input  logic                  i_canIssue,
    input  logic                  i_ioFull,
    output logic                  o_reqReady,
    output memAddr_t              o_memAddr,
    output logic                  o_memWrite,
    output memByte_t              o_memWdata,
    output logic                  o_tagValid,
    output laneIdx_t              o_tagLane,
    output logic                  o_tagLast,
    output reqSource_t            o_tagSource,
    output accessSize_t           o_tagSize,
    output memOp_t                o_tagOp
);

    logic        busy;
    byteCount_t  byteIdx;
    memAddr_t    curAddr;
    laneWord_t   curWdata;
    accessSize_t curSize;
    memOp_t      curOp;
    reqSource_t  curSource;
    laneIdx_t    curLane;
    logic        lastByte;
    logic        issue;
    logic        take;

    assign curLane  = laneIdx_t'(byteIdx);
    assign lastByte = (byteIdx == bytesOf(curSize) - 3'd1);

    // one byte per cycle unless the queue is backed up or the I/O buffer is full
    assign issue = busy && i_canIssue && !i_ioFull;

    // ready already while the last byte goes out, next request follows without a gap
    assign o_reqReady = !busy || (issue && lastByte);
    assign take       = i_reqValid && o_reqReady;

    assign o_memAddr  = curAddr + ADDR_WIDTH'(byteIdx);
    assign o_memWrite = issue && (curOp == opWrite);
    assign o_memWdata = curWdata.lanes[curLane];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            byteIdx <= '0;
        end else if (take) begin
            busy    <= 1'b1;
            byteIdx <= '0;
        end else if (issue) begin
            if (lastByte) begin
                busy <= 1'b0;
            end else begin
                byteIdx <= byteIdx + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            curAddr        <= i_reqAddr;
            curWdata.word  <= i_reqWdata;
            curSize        <= i_reqSize;
            curOp          <= i_reqOp;
            curSource      <= i_reqSource;
        end
    end

    // tag lines up with the RAM read data one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            o_tagValid <= 1'b0;
        end else begin
            o_tagValid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        o_tagLane   <= curLane;
        o_tagLast   <= lastByte;
        o_tagSource <= curSource;
        o_tagSize   <= curSize;
        o_tagOp     <= curOp;
    end

endmodule

// File: logic/byteAssembler.sv
`timescale 1ns/1ps

module byteAssembler
    import memBusPkg::*, memReqPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_tagValid,
    input  laneIdx_t              i_tagLane,
    input  logic                  i_tagLast,
    input  reqSource_t            i_tagSource,
    input  accessSize_t           i_tagSize,
    input  memOp_t                i_tagOp,
    input  memByte_t              i_memRdata,
    input  logic                  i_fetchRespReady,
    input  logic                  i_dataRespReady,
    output logic                  o_canIssue,
    output logic                  o_fetchRespValid,
    output logic [WORD_WIDTH-1:0] o_fetchInst,
    output logic                  o_dataRespValid,
    output logic [WORD_WIDTH-1:0] o_dataRdata
);

    laneWord_t  partWord;
    laneWord_t  mergedWord;
    laneWord_t  fillWord;
    laneWord_t  qWord [2];
    reqSource_t qSource [2];
    logic       wrPtr;
    logic       rdPtr;
    logic [1:0] count;
    logic       headValid;
    logic       push;
    logic       pop;

    // drop the returned byte into its lane
    always_comb begin
        mergedWord = partWord;
        if (i_tagOp == opRead) begin
            mergedWord.lanes[i_tagLane] = i_memRdata;
        end
    end

    // lanes above the access size read as zero, a store answers with zero
    always_comb begin
        fillWord = mergedWord;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (i_tagOp == opWrite || i >= int'(bytesOf(i_tagSize))) begin
                fillWord.lanes[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_tagValid) begin
            partWord <= mergedWord;
        end
    end

    assign push = i_tagValid && i_tagLast;

    // two-entry response queue, head steered by source
    assign headValid        = (count != 2'd0);
    assign o_fetchRespValid = headValid && (qSource[rdPtr] == srcFetch);
    assign o_dataRespValid  = headValid && (qSource[rdPtr] == srcData);
    assign o_fetchInst      = qWord[rdPtr].word;
    assign o_dataRdata      = qWord[rdPtr].word;

    assign pop = (o_fetchRespValid && i_fetchRespReady)
              || (o_dataRespValid && i_dataRespReady);

    // bytes already issued can still land two more entries, so only
    // allow new issue when the queue is empty after this cycle's pop
    assign o_canIssue = (count == 2'd0) || (count == 2'd1 && pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
            count <= 2'd0;
        end else begin
            if (push) begin
                wrPtr <= !wrPtr;
            end
            if (pop) begin
                rdPtr <= !rdPtr;
            end
            count <= count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            qWord[wrPtr]   <= fillWord;
            qSource[wrPtr] <= i_tagSource;
        end
    end

endmodule

// File: logic/memCtrlTop.sv
`timescale 1ns/1ps

module memCtrlTop
    import memBusPkg::*, memReqPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_ioFull,
    input  logic                  i_fetchValid,
    output logic                  o_fetchReady,
    input  memAddr_t              i_fetchAddr,
    input  logic                  i_dataValid,
    output logic                  o_dataReady,
    input  memOp_t                i_dataOp,
    input  accessSize_t           i_dataSize,
    input  memAddr_t              i_dataAddr,
    input  logic [WORD_WIDTH-1:0] i_dataWdata,
    output logic                  o_fetchRespValid,
    input  logic                  i_fetchRespReady,
    output logic [WORD_WIDTH-1:0] o_fetchInst,
    output logic                  o_dataRespValid,
    input  logic                  i_dataRespReady,
    output logic [WORD_WIDTH-1:0] o_dataRdata,
    output memAddr_t              o_memAddr,
    output logic                  o_memWrite,
    output memByte_t              o_memWdata,
    input  memByte_t              i_memRdata
);

    // arbiter to sequencer
    logic                  reqValid;
    logic                  reqReady;
    memOp_t                reqOp;
    accessSize_t           reqSize;
    reqSource_t            reqSource;
    memAddr_t              reqAddr;
    logic [WORD_WIDTH-1:0] reqWdata;

    // sequencer to assembler
    logic                  tagValid;
    laneIdx_t              tagLane;
    logic                  tagLast;
    reqSource_t            tagSource;
    accessSize_t           tagSize;
    memOp_t                tagOp;
    logic                  canIssue;

    requestArbiter requestArbiter_inst (
        .clk(clk), .rst(rst),
        .i_fetchValid(i_fetchValid), .i_fetchAddr(i_fetchAddr),
        .i_dataValid(i_dataValid), .i_dataOp(i_dataOp), .i_dataSize(i_dataSize),
        .i_dataAddr(i_dataAddr), .i_dataWdata(i_dataWdata),
        .i_reqReady(reqReady),
        .o_fetchReady(o_fetchReady), .o_dataReady(o_dataReady),
        .o_reqValid(reqValid), .o_reqOp(reqOp), .o_reqSize(reqSize),
        .o_reqSource(reqSource), .o_reqAddr(reqAddr), .o_reqWdata(reqWdata)
    );

    byteSequencer byteSequencer_inst (
        .clk(clk), .rst(rst),
        .i_reqValid(reqValid), .i_reqOp(reqOp), .i_reqSize(reqSize),
        .i_reqSource(reqSource), .i_reqAddr(reqAddr), .i_reqWdata(reqWdata),
        .i_canIssue(canIssue), .i_ioFull(i_ioFull),
        .o_reqReady(reqReady),
        .o_memAddr(o_memAddr), .o_memWrite(o_memWrite), .o_memWdata(o_memWdata),
        .o_tagValid(tagValid), .o_tagLane(tagLane), .o_tagLast(tagLast),
        .o_tagSource(tagSource), .o_tagSize(tagSize), .o_tagOp(tagOp)
    );

    byteAssembler byteAssembler_inst (
        .clk(clk), .rst(rst),
        .i_tagValid(tagValid), .i_tagLane(tagLane), .i_tagLast(tagLast),
        .i_tagSource(tagSource), .i_tagSize(tagSize), .i_tagOp(tagOp),
        .i_memRdata(i_memRdata),
        .i_fetchRespReady(i_fetchRespReady), .i_dataRespReady(i_dataRespReady),
        .o_canIssue(canIssue),
        .o_fetchRespValid(o_fetchRespValid), .o_fetchInst(o_fetchInst),
        .o_dataRespValid(o_dataRespValid), .o_dataRdata(o_dataRdata)
    );

endmodule

// File: bench/memCtrlTop_assertions.sv
`timescale 1ns/1ps

module memCtrlTop_assertions
    import memBusPkg::*, memReqPkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  i_ioFull,
    input logic                  i_fetchValid,
    input logic                  i_fetchReady,
    input memAddr_t              i_fetchAddr,
    input logic                  i_dataValid,
    input logic                  i_dataReady,
    input memOp_t                i_dataOp,
    input accessSize_t           i_dataSize,
    input memAddr_t              i_dataAddr,
    input logic [WORD_WIDTH-1:0] i_dataWdata,
    input logic                  i_fetchRespValid,
    input logic                  i_fetchRespReady,
    input logic [WORD_WIDTH-1:0] i_fetchInst,
    input logic                  i_dataRespValid,
    input logic                  i_dataRespReady,
    input logic [WORD_WIDTH-1:0] i_dataRdata,
    input logic                  i_memWrite
);

    int violations = 0;

    // requests hold until taken
    fetchReqHeld: assert property (@(posedge clk) disable iff (rst)
        i_fetchValid && !i_fetchReady |=> i_fetchValid && $stable(i_fetchAddr))
        else begin
            violations++;
            $error("fetch request changed before it was accepted");
        end

    dataReqHeld: assert property (@(posedge clk) disable iff (rst)
        i_dataValid && !i_dataReady |=> i_dataValid && $stable(i_dataOp)
            && $stable(i_dataSize) && $stable(i_dataAddr) && $stable(i_dataWdata))
        else begin
            violations++;
            $error("data request changed before it was accepted");
        end

    // responses hold until taken
    fetchRespHeld: assert property (@(posedge clk) disable iff (rst)
        i_fetchRespValid && !i_fetchRespReady |=> i_fetchRespValid && $stable(i_fetchInst))
        else begin
            violations++;
            $error("fetch response dropped or changed while stalled");
        end

    dataRespHeld: assert property (@(posedge clk) disable iff (rst)
        i_dataRespValid && !i_dataRespReady |=> i_dataRespValid && $stable(i_dataRdata))
        else begin
            violations++;
            $error("data response dropped or changed while stalled");
        end

    noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
        !(i_ioFull && i_memWrite))
        else begin
            violations++;
            $error("RAM write issued while the I/O buffer was full");
        end

    dataBeatsFetch: assert property (@(posedge clk) disable iff (rst)
        i_dataValid |-> !i_fetchReady)
        else begin
            violations++;
            $error("fetch ready high while a data request was pending");
        end

endmodule

// File: bench/memCtrlTb.sv
`timescale 1ns/1ps

module memCtrlTb
    import memBusPkg::*, memReqPkg::*;
();

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  ioFull;
    logic                  fetchValid;
    logic                  fetchReady;
    memAddr_t              fetchAddr;
    logic                  dataValid;
    logic                  dataReady;
    memOp_t                dataOp;
    accessSize_t           dataSize;
    memAddr_t              dataAddr;
    logic [WORD_WIDTH-1:0] dataWdata;
    logic                  fetchRespValid;
    logic                  fetchRespReady;
    logic [WORD_WIDTH-1:0] fetchInst;
    logic                  dataRespValid;
    logic                  dataRespReady;
    logic [WORD_WIDTH-1:0] dataRdata;
    memAddr_t              memAddr;
    logic                  memWrite;
    memByte_t              memWdata;
    memByte_t              memRdata;

    integer      seed = 32'h4a82;
    int          stimPort[$];
    int          stimOp[$];
    int          stimBytes[$];
    logic [31:0] stimAddr[$];
    logic [31:0] stimWdata[$];
    logic [31:0] stimExp[$];
    int          fetchList[$];
    int          dataList[$];
    int          fetchDone = 0;
    int          dataDone = 0;
    int          cycleCount = 0;
    int          cycleLimit;
    memByte_t    ram [256];

    always #5 clk = ~clk;

    memCtrlTop memCtrlTop_inst (
        .clk(clk), .rst(rst), .i_ioFull(ioFull),
        .i_fetchValid(fetchValid), .o_fetchReady(fetchReady), .i_fetchAddr(fetchAddr),
        .i_dataValid(dataValid), .o_dataReady(dataReady), .i_dataOp(dataOp),
        .i_dataSize(dataSize), .i_dataAddr(dataAddr), .i_dataWdata(dataWdata),
        .o_fetchRespValid(fetchRespValid), .i_fetchRespReady(fetchRespReady),
        .o_fetchInst(fetchInst),
        .o_dataRespValid(dataRespValid), .i_dataRespReady(dataRespReady),
        .o_dataRdata(dataRdata),
        .o_memAddr(memAddr), .o_memWrite(memWrite), .o_memWdata(memWdata),
        .i_memRdata(memRdata)
    );

    bind memCtrlTop memCtrlTop_assertions protocolChecks (
        .clk(clk), .rst(rst), .i_ioFull(i_ioFull),
        .i_fetchValid(i_fetchValid), .i_fetchReady(o_fetchReady), .i_fetchAddr(i_fetchAddr),
        .i_dataValid(i_dataValid), .i_dataReady(o_dataReady), .i_dataOp(i_dataOp),
        .i_dataSize(i_dataSize), .i_dataAddr(i_dataAddr), .i_dataWdata(i_dataWdata),
        .i_fetchRespValid(o_fetchRespValid), .i_fetchRespReady(i_fetchRespReady),
        .i_fetchInst(o_fetchInst),
        .i_dataRespValid(o_dataRespValid), .i_dataRespReady(i_dataRespReady),
        .i_dataRdata(o_dataRdata), .i_memWrite(o_memWrite)
    );

    // byte RAM, read data one cycle after the address
    initial begin
        for (int a = 0; a < 256; a++) begin
            ram[a] = 8'(a) ^ 8'h5A;
        end
    end

    always @(posedge clk) begin
        memRdata <= ram[memAddr[7:0]];
        if (memWrite) begin
            ram[memAddr[7:0]] <= memWdata;
        end
    end

    task automatic stopWithFailure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic string describe(input int idx);
        return $sformatf("case%0d_%s_%s%0d_at_%02h", idx, stimPort[idx] ? "data" : "fetch",
                         stimOp[idx] ? "wr" : "rd", stimBytes[idx], stimAddr[idx][7:0]);
    endfunction

    function automatic accessSize_t sizeFromBytes(input int n);
        if (n == 1) begin
            return sizeByte;
        end
        if (n == 2) begin
            return sizeHalf;
        end
        return sizeWord;
    endfunction

    task automatic readStimulusFile();
        int          fd;
        int          got;
        string       line;
        logic [31:0] port;
        logic [31:0] op;
        logic [31:0] nBytes;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expVal;
        fd = $fopen("bench/memCases.txt", "r");
        assert (fd != 0) else begin
            $display("could not open bench/memCases.txt");
            stopWithFailure();
        end
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got > 1 && line.getc(0) != "#") begin
                got = $sscanf(line, "%h %h %h %h %h %h", port, op, nBytes, addr, wdata, expVal);
                if (got == 6) begin
                    if (port != 0) begin
                        dataList.push_back(stimAddr.size());
                    end else begin
                        fetchList.push_back(stimAddr.size());
                    end
                    stimPort.push_back(int'(port));
                    stimOp.push_back(int'(op));
                    stimBytes.push_back(int'(nBytes));
                    stimAddr.push_back(addr);
                    stimWdata.push_back(wdata);
                    stimExp.push_back(expVal);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic compareResponse(input int idx, input logic [31:0] actual);
        assert (actual === stimExp[idx]) else begin
            $display("** Error %s expected %08h actual %08h", describe(idx), stimExp[idx], actual);
            stopWithFailure();
        end
    endtask

    // one request per call, held until ready is seen before an edge
    task automatic waitAccepted(input bit isData);
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = isData ? dataReady : fetchReady;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic idleGap();
        if (($random(seed) & 3) == 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic sendFetches();
        foreach (fetchList[k]) begin
            fetchValid = 1'b1;
            fetchAddr  = stimAddr[fetchList[k]];
            waitAccepted(1'b0);
            fetchValid = 1'b0;
            idleGap();
        end
    endtask

    task automatic sendDataRequests();
        int idx;
        foreach (dataList[k]) begin
            idx       = dataList[k];
            dataValid = 1'b1;
            dataOp    = stimOp[idx] ? opWrite : opRead;
            dataSize  = sizeFromBytes(stimBytes[idx]);
            dataAddr  = stimAddr[idx];
            dataWdata = stimWdata[idx];
            waitAccepted(1'b1);
            dataValid = 1'b0;
            idleGap();
        end
    endtask

    // response readies and I/O stalls change just after each edge
    initial begin
        forever begin
            @(posedge clk);
            #1;
            fetchRespReady = ($random(seed) & 3) != 0;
            dataRespReady  = ($random(seed) & 3) != 0;
            ioFull         = ($random(seed) & 7) == 0;
        end
    end

    // take responses in order on each port
    always @(negedge clk) begin
        if (fetchRespValid && fetchRespReady) begin
            assert (fetchDone < fetchList.size()) else begin
                $display("fetch response arrived with no fetch outstanding");
                stopWithFailure();
            end
            compareResponse(fetchList[fetchDone], fetchInst);
            fetchDone++;
        end
    end

    always @(negedge clk) begin
        if (dataRespValid && dataRespReady) begin
            assert (dataDone < dataList.size()) else begin
                $display("data response arrived with no data request outstanding");
                stopWithFailure();
            end
            compareResponse(dataList[dataDone], dataRdata);
            dataDone++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
    end

    always @(negedge clk) begin
        assert (cycleCount < cycleLimit) else begin
            $display("timeout after %0d cycles with responses still missing", cycleCount);
            stopWithFailure();
        end
    end

    always @(negedge clk) begin
        assert (memCtrlTop_inst.protocolChecks.violations == 0) else begin
            $display("a bound protocol assertion failed");
            stopWithFailure();
        end
    end

    initial begin
        rst            = 1'b1;
        ioFull         = 1'b0;
        fetchValid     = 1'b0;
        fetchAddr      = '0;
        dataValid      = 1'b0;
        dataOp         = opRead;
        dataSize       = sizeByte;
        dataAddr       = '0;
        dataWdata      = '0;
        fetchRespReady = 1'b0;
        dataRespReady  = 1'b0;
        memRdata       = '0;
        readStimulusFile();
        cycleLimit = 40 * stimAddr.size() + 100;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            sendFetches();
            sendDataRequests();
        join
        wait (fetchDone == fetchList.size() && dataDone == dataList.size());
        repeat (8) @(posedge clk);
        if (!fetchRespValid && !dataRespValid) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("response left over after all requests completed");
            stopWithFailure();
        end
    end

endmodule

// File: vlog.f
logic/memBusPkg.sv
logic/memReqPkg.sv
logic/requestArbiter.sv
logic/byteSequencer.sv
logic/byteAssembler.sv
logic/memCtrlTop.sv
bench/memCtrlTop_assertions.sv
bench/memCtrlTb.sv

// File: bench/memCases.txt
# port (0 fetch, 1 data)  op (0 read, 1 write)  bytes (1, 2, 4)
# addr  store data  expected response, all in hex
0 0 4 00000000 00000000 59585B5A
1 0 1 00000005 00000000 0000005F
0 0 4 00000004 00000000 5D5C5F5E
1 0 2 00000006 00000000 00005D5C
1 0 4 00000020 00000000 79787B7A
0 0 4 00000010 00000000 49484B4A
1 1 1 00000084 000000A5 00000000
1 0 4 00000084 00000000 DDDCDFA5
0 0 4 00000021 00000000 7E79787B
1 1 2 00000088 1234C3B2 00000000
1 0 4 00000088 00000000 D1D0C3B2
1 0 2 00000089 00000000 0000D0C3
0 0 4 0000003C 00000000 65646766
1 1 4 00000090 3C1E9A77 00000000
1 0 4 00000090 00000000 3C1E9A77
1 0 1 00000033 00000000 00000069
1 1 1 000000A3 FFFFFF11 00000000
1 0 4 000000A0 00000000 11F8FBFA
0 0 4 00000008 00000000 51505352
1 0 2 00000041 00000000 0000181B
1 0 4 00000080 00000000 D9D8DBDA
